/* rtl/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

  localparam int POSIT_SIZE = 8;
  localparam int MAX_K = POSIT_SIZE - 2;  // largest regime value k.
  localparam int TE_SIZE = 5;
  localparam int MANT_SIZE = 6;
  localparam int FRAC_FULL_SIZE = 12;
  localparam int MANT_ADD_RESULT_SIZE = 8;
  localparam int MANT_MUL_RESULT_SIZE = 12;
  localparam int MANT_DIV_RESULT_SIZE = 12;
  localparam int OP_SIZE = 2;
  localparam int APB_ADDR_SIZE = 5;
  localparam int APB_DATA_SIZE = 32;

  typedef logic [POSIT_SIZE-1:0] posit_t;
  typedef logic signed [TE_SIZE-1:0] te_t;
  typedef logic [MANT_SIZE-1:0] mant_t;  // hidden one plus fraction, 1.5 format.
  typedef logic [FRAC_FULL_SIZE-1:0] frac_t;
  typedef logic [APB_ADDR_SIZE-1:0] apb_addr_t;
  typedef logic [APB_DATA_SIZE-1:0] apb_data_t;

  localparam posit_t POSIT_ZERO = 8'h00;
  localparam posit_t POSIT_NAR = 8'h80;

  typedef enum logic [OP_SIZE-1:0] {
    ADD,
    SUB,
    MUL,
    DIV
  } op_e;

  typedef struct packed {
    logic  sign;
    te_t   te;
    mant_t mant;
    logic  is_zero;
    logic  is_nar;
  } decoded_t;

  typedef struct packed {
    logic  sign;
    te_t   te;
    frac_t frac;
    logic  frac_truncated;
    logic  is_zero;
    logic  is_nar;
    logic  valid;
  } core_result_t;

  typedef struct packed {
    op_e    op;
    posit_t p1;
    posit_t p2;
    logic   start;
  } ppu_req_t;

  typedef struct packed {
    posit_t result;
    logic   inexact;
    logic   valid;
  } ppu_rsp_t;

  localparam apb_addr_t ADDR_OPERANDS = 'h0;
  localparam apb_addr_t ADDR_CTRL = 'h4;
  localparam apb_addr_t ADDR_RESULT = 'h8;
  localparam apb_addr_t ADDR_STATUS = 'hC;

endpackage

`default_nettype wire

/* rtl/posit_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module posit_decode
  import ppu_pkg::*;
(
  input  posit_t   posit,
  output decoded_t dec
);

  posit_t mag;
  logic [3:0] run;
  logic stop;
  logic [POSIT_SIZE+MANT_SIZE-3:0] body;
  logic special;

  always_comb begin
    mag = posit[POSIT_SIZE-1] ? posit_t'(-posit) : posit;
    run = '0;
    stop = 1'b0;
    // length of the regime run, starting right after the sign.
    for (int i = POSIT_SIZE - 2; i >= 0; i--) begin
      if (!stop && (mag[i] == mag[POSIT_SIZE-2])) begin
        run = run + 4'd1;
      end else begin
        stop = 1'b1;
      end
    end
    // drop the run and its terminating bit.
    body = {mag[POSIT_SIZE-2:0], {(MANT_SIZE - 1) {1'b0}}} << (run + 4'd1);
  end

  assign special = (posit == POSIT_ZERO) || (posit == POSIT_NAR);

  always_comb begin
    dec.sign = posit[POSIT_SIZE-1];
    dec.is_zero = posit == POSIT_ZERO;
    dec.is_nar = posit == POSIT_NAR;
    if (special) begin
      dec.te = '0;
      dec.mant = '0;  // a zero mantissa never wins the add ordering.
    end else begin
      dec.te = mag[POSIT_SIZE-2] ? te_t'(run) - te_t'(1) : -te_t'(run);
      dec.mant = {1'b1, body[POSIT_SIZE+MANT_SIZE-3 -: MANT_SIZE-1]};
    end
  end

endmodule

`default_nettype wire

/* rtl/core_add_sub.sv */
`timescale 1ns/1ns
`default_nettype none

module core_add_sub
  import ppu_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  te_t                             te1_in,
  input  te_t                             te2_in,
  input  mant_t                           mant1_in,
  input  mant_t                           mant2_in,
  input  logic                            have_opposite_sign,
  output logic [MANT_ADD_RESULT_SIZE-1:0] mant_out,
  output te_t                             te_out,
  output logic                            frac_truncated,
  output logic                            sign_swap
);

  logic swap;
  te_t te_big, te_small, te_norm;
  mant_t mant_big, mant_small;
  logic [TE_SIZE:0] diff;
  logic [3:0] shamt;
  logic [MANT_SIZE+19:0] small_wide;
  logic [MANT_SIZE+3:0] big_ext, small_jam, sum;
  logic [MANT_SIZE+2:0] norm;
  logic [3:0] lz;
  logic found, lost;

  // bigger magnitude goes first; a zero operand never does.
  assign swap = (mant1_in == '0) || ((mant2_in != '0) && ((te2_in > te1_in) ||
                ((te2_in == te1_in) && (mant2_in > mant1_in))));

  always_comb begin
    te_big = swap ? te2_in : te1_in;
    te_small = swap ? te1_in : te2_in;
    mant_big = swap ? mant2_in : mant1_in;
    mant_small = swap ? mant1_in : mant2_in;
    diff = {te_big[TE_SIZE-1], te_big} - {te_small[TE_SIZE-1], te_small};
    shamt = (diff > 6'd15) ? 4'd15 : diff[3:0];
    small_wide = {1'b0, mant_small, 3'b0, 16'b0} >> shamt;
    small_jam = small_wide[MANT_SIZE+19:16] | {{(MANT_SIZE + 3) {1'b0}}, |small_wide[15:0]};
    big_ext = {1'b0, mant_big, 3'b0};
    sum = have_opposite_sign ? big_ext - small_jam : big_ext + small_jam;
  end

  // leading-one count below the carry bit.
  always_comb begin
    lz = '0;
    found = 1'b0;
    for (int i = MANT_SIZE + 2; i >= 0; i--) begin
      if (!found) begin
        if (sum[i]) begin
          found = 1'b1;
        end else begin
          lz = lz + 4'd1;
        end
      end
    end
  end

  always_comb begin
    if (sum[MANT_SIZE+3]) begin
      norm = sum[MANT_SIZE+3:1];
      lost = sum[0];
      te_norm = te_big + te_t'(1);
    end else begin
      norm = sum[MANT_SIZE+2:0] << lz;
      lost = 1'b0;
      te_norm = te_big - te_t'(lz);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mant_out <= '0;
      te_out <= '0;
      frac_truncated <= 1'b0;
      sign_swap <= 1'b0;
    end else begin
      mant_out <= {1'b0, norm[MANT_SIZE+2:2]};  // zero here flags a zero difference.
      te_out <= te_norm;
      frac_truncated <= (|norm[1:0]) | lost;
      sign_swap <= swap;
    end
  end

endmodule

`default_nettype wire

/* rtl/core_mul.sv */
`timescale 1ns/1ns
`default_nettype none

module core_mul
  import ppu_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  te_t                             te1,
  input  te_t                             te2,
  input  mant_t                           mant1,
  input  mant_t                           mant2,
  output logic [MANT_MUL_RESULT_SIZE-1:0] mant_out,
  output te_t                             te_out,
  output logic                            frac_truncated
);

  logic [MANT_MUL_RESULT_SIZE-1:0] prod;

  assign prod = mant1 * mant2;  // 2.10 format.

  always_ff @(posedge clk) begin
    if (rst) begin
      mant_out <= '0;
      te_out <= '0;
      frac_truncated <= 1'b0;
    end else begin
      mant_out <= prod;
      te_out <= te1 + te2 + te_t'(prod[MANT_MUL_RESULT_SIZE-1]);
      frac_truncated <= 1'b0;  // full product, nothing dropped.
    end
  end

endmodule

`default_nettype wire

/* rtl/core_div.sv */
`timescale 1ns/1ns
`default_nettype none

module core_div
  import ppu_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  te_t                             te1,
  input  te_t                             te2,
  input  mant_t                           mant1,
  input  mant_t                           mant2,
  output logic [MANT_DIV_RESULT_SIZE-1:0] mant_out,
  output te_t                             te_out,
  output logic                            frac_truncated
);

  logic lt;
  logic [MANT_SIZE+1:0] rem;
  logic [MANT_DIV_RESULT_SIZE-1:0] quo;

  always_comb begin
    lt = mant1 < mant2;
    // pre-doubling keeps the quotient in [1, 2).
    rem = lt ? {1'b0, mant1, 1'b0} : {2'b0, mant1};
    for (int i = MANT_DIV_RESULT_SIZE - 1; i >= 0; i--) begin
      if (rem >= {2'b0, mant2}) begin
        quo[i] = 1'b1;
        rem = rem - {2'b0, mant2};
      end else begin
        quo[i] = 1'b0;
      end
      rem = rem << 1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mant_out <= '0;
      te_out <= '0;
      frac_truncated <= 1'b0;
    end else begin
      mant_out <= quo;  // 1.11 format.
      te_out <= te1 - te2 - te_t'(lt);
      frac_truncated <= rem != '0;
    end
  end

endmodule

`default_nettype wire

/* rtl/core_op.sv */
`timescale 1ns/1ns
`default_nettype none

module core_op
  import ppu_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  op_e          op,
  input  logic         valid,
  input  decoded_t     a,
  input  decoded_t     b,
  output core_result_t res
);

  logic [MANT_ADD_RESULT_SIZE-1:0] mant_add;
  logic [MANT_MUL_RESULT_SIZE-1:0] mant_mul;
  logic [MANT_DIV_RESULT_SIZE-1:0] mant_div;
  te_t te_add, te_mul, te_div;
  logic trunc_add, trunc_mul, trunc_div;
  logic swap_add;
  logic sign_b_eff;
  op_e op_q;
  logic sign_a_q, sign_b_q, zero_q, nar_q, valid_q;

  assign sign_b_eff = b.sign ^ (op == SUB);

  core_add_sub core_add_sub_inst (
    .clk(clk),
    .rst(rst),
    .te1_in(a.te),
    .te2_in(b.te),
    .mant1_in(a.mant),
    .mant2_in(b.mant),
    .have_opposite_sign(a.sign ^ sign_b_eff),
    .mant_out(mant_add),
    .te_out(te_add),
    .frac_truncated(trunc_add),
    .sign_swap(swap_add)
  );

  core_mul core_mul_inst (
    .clk(clk),
    .rst(rst),
    .te1(a.te),
    .te2(b.te),
    .mant1(a.mant),
    .mant2(b.mant),
    .mant_out(mant_mul),
    .te_out(te_mul),
    .frac_truncated(trunc_mul)
  );

  core_div core_div_inst (
    .clk(clk),
    .rst(rst),
    .te1(a.te),
    .te2(b.te),
    .mant1(a.mant),
    .mant2(b.mant),
    .mant_out(mant_div),
    .te_out(te_div),
    .frac_truncated(trunc_div)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid;
    end
  end

  always_ff @(posedge clk) begin
    op_q <= op;
    sign_a_q <= a.sign;
    sign_b_q <= sign_b_eff;
    nar_q <= a.is_nar | b.is_nar | ((op == DIV) & b.is_zero);
    case (op)
      ADD, SUB: zero_q <= a.is_zero & b.is_zero;
      MUL: zero_q <= a.is_zero | b.is_zero;
      default: zero_q <= a.is_zero;
    endcase
  end

  always_comb begin
    res.valid = valid_q;
    res.is_nar = nar_q;
    case (op_q)
      ADD, SUB: begin
        res.sign = swap_add ? sign_b_q : sign_a_q;
        res.te = te_add;
        res.frac = {mant_add, 4'b0} << 2;  // chop carry and hidden bit.
        res.frac_truncated = trunc_add;
        res.is_zero = zero_q | (mant_add == '0);
      end
      MUL: begin
        res.sign = sign_a_q ^ sign_b_q;
        res.te = te_mul;
        res.frac = mant_mul[MANT_MUL_RESULT_SIZE-1] ? mant_mul << 1 : mant_mul << 2;
        res.frac_truncated = trunc_mul;
        res.is_zero = zero_q;
      end
      default: begin
        res.sign = sign_a_q ^ sign_b_q;
        res.te = te_div;
        res.frac = mant_div << 1;  // quotient is already in [1, 2).
        res.frac_truncated = trunc_div;
        res.is_zero = zero_q;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/posit_encode.sv */
`timescale 1ns/1ns
`default_nettype none

module posit_encode
  import ppu_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  core_result_t res,
  output ppu_rsp_t     rsp
);

  logic sat_hi, sat_lo;
  te_t te_c;
  logic [POSIT_SIZE+FRAC_FULL_SIZE-1:0] seq;
  logic [POSIT_SIZE-2:0] body, mag;
  logic guard, sticky, round_up, inexact;
  posit_t word;

  always_comb begin
    sat_hi = res.te > te_t'(MAX_K);
    sat_lo = res.te < -te_t'(MAX_K);
    te_c = sat_hi ? te_t'(MAX_K) : (sat_lo ? -te_t'(MAX_K) : res.te);
    // regime run, terminator, then the fraction.
    if (!te_c[TE_SIZE-1]) begin
      seq = {{(POSIT_SIZE - 1) {1'b1}}, 1'b0, res.frac} << (MAX_K - te_c);
    end else begin
      seq = {1'b1, res.frac, {(POSIT_SIZE - 1) {1'b0}}} >> (-te_c);
    end
    body = seq[POSIT_SIZE+FRAC_FULL_SIZE-1 -: POSIT_SIZE-1];
    guard = seq[FRAC_FULL_SIZE];
    sticky = (|seq[FRAC_FULL_SIZE-1:0]) | res.frac_truncated;
    round_up = guard & (sticky | body[0]);  // nearest, ties to even.
    if (sat_hi) begin
      mag = '1;
    end else if (sat_lo) begin
      mag = {{(POSIT_SIZE - 2) {1'b0}}, 1'b1};
    end else begin
      mag = body + {{(POSIT_SIZE - 2) {1'b0}}, round_up};
    end
    inexact = sat_hi | sat_lo | guard | sticky;
    word = res.sign ? posit_t'(-{1'b0, mag}) : {1'b0, mag};
    if (res.is_nar) begin
      word = POSIT_NAR;
      inexact = 1'b0;
    end else if (res.is_zero) begin
      word = POSIT_ZERO;
      inexact = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp <= '0;
    end else begin
      rsp.result <= word;
      rsp.inexact <= inexact;
      rsp.valid <= res.valid;
    end
  end

endmodule

`default_nettype wire

/* rtl/ppu_apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module ppu_apb_regs
  import ppu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  output ppu_req_t  req,
  input  ppu_rsp_t  rsp
);

  logic access, mapped, wr_en, rd_en;
  posit_t p1, p2;
  op_e op;
  logic start;
  posit_t result;
  logic inexact;
  logic done;
  logic [1:0] inflight;

  assign access = psel & penable;
  assign mapped = paddr inside {ADDR_OPERANDS, ADDR_CTRL, ADDR_RESULT, ADDR_STATUS};
  assign wr_en = access & pwrite & mapped;
  assign rd_en = access & ~pwrite & mapped;

  assign pready = 1'b1;  // no wait states.
  assign pslverr = access & ~mapped;

  always_ff @(posedge clk) begin
    if (rst) begin
      p1 <= '0;
      p2 <= '0;
      op <= ADD;
      start <= 1'b0;
    end else begin
      start <= wr_en && (paddr == ADDR_CTRL);
      if (wr_en && (paddr == ADDR_OPERANDS)) begin
        p1 <= pwdata[7:0];
        p2 <= pwdata[15:8];
      end
      if (wr_en && (paddr == ADDR_CTRL)) begin
        op <= op_e'(pwdata[OP_SIZE-1:0]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
      inexact <= 1'b0;
      done <= 1'b0;
      inflight <= '0;
    end else begin
      if (rsp.valid) begin  // a new result wins over a clearing read.
        result <= rsp.result;
        inexact <= rsp.inexact;
        done <= 1'b1;
      end else if (rd_en && (paddr == ADDR_RESULT)) begin
        done <= 1'b0;
      end
      case ({start, rsp.valid})
        2'b10: inflight <= inflight + 2'd1;
        2'b01: inflight <= inflight - 2'd1;
        default: inflight <= inflight;
      endcase
    end
  end

  always_comb begin
    prdata = '0;
    if (rd_en) begin
      case (paddr)
        ADDR_OPERANDS: prdata = {16'b0, p2, p1};
        ADDR_CTRL: prdata = {{(APB_DATA_SIZE - OP_SIZE) {1'b0}}, op};
        ADDR_RESULT: prdata = {23'b0, inexact, result};
        default: prdata = {30'b0, inflight != 2'd0, done};  // status.
      endcase
    end
  end

  assign req = '{op: op, p1: p1, p2: p2, start: start};

endmodule

`default_nettype wire

/* rtl/ppu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ppu_top
  import ppu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  ppu_req_t req;
  ppu_rsp_t rsp;
  decoded_t dec_a, dec_b, dec_a_q, dec_b_q;
  op_e op_q;
  logic valid_q;
  core_result_t core_res;

  ppu_apb_regs ppu_apb_regs_inst (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .req(req),
    .rsp(rsp)
  );

  posit_decode posit_decode_a_inst (
    .posit(req.p1),
    .dec(dec_a)
  );

  posit_decode posit_decode_b_inst (
    .posit(req.p2),
    .dec(dec_b)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.start;
    end
  end

  always_ff @(posedge clk) begin
    dec_a_q <= dec_a;  // decode stage register.
    dec_b_q <= dec_b;
    op_q <= req.op;
  end

  core_op core_op_inst (
    .clk(clk),
    .rst(rst),
    .op(op_q),
    .valid(valid_q),
    .a(dec_a_q),
    .b(dec_b_q),
    .res(core_res)
  );

  posit_encode posit_encode_inst (
    .clk(clk),
    .rst(rst),
    .res(core_res),
    .rsp(rsp)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 5;  // 10 ns period.

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

`default_nettype wire

/* testbench/ppu_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module ppu_assertions
  import ppu_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     psel,
  input logic     penable,
  input logic     start,
  input ppu_rsp_t rsp
);

  // decode, core and encode registers sit between start and the response.
  a_valid_after_start: assert property (@(posedge clk) disable iff (rst)
    start |-> ##3 rsp.valid)
    else $error("rsp valid missing 3 cycles after start");

  a_valid_needs_start: assert property (@(posedge clk) disable iff (rst)
    rsp.valid |-> $past(start, 3))
    else $error("rsp valid without a start 3 cycles earlier");

  a_penable_after_psel: assert property (@(posedge clk) disable iff (rst)
    penable |-> psel && $past(psel))
    else $error("penable without a preceding setup phase");

endmodule

`default_nettype wire

/* testbench/ppu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ppu_tb
  import ppu_pkg::*;
();

  localparam int SAMPLE_DELAY = 2;  // into the low clock phase.
  localparam int POLL_LIMIT = 50;

  logic clk, rst, psel, penable, pwrite, pready, pslverr;
  apb_addr_t paddr;
  apb_data_t pwdata, prdata;
  integer seed;

  tb_clock_gen u_clk (
    .clk(clk)
  );

  ppu_top u_dut (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr)
  );

  bind ppu_apb_regs ppu_assertions u_assertions (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .start(start),
    .rsp(rsp)
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // one APB transfer, setup then access, sampled inside the access phase.
  task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    #SAMPLE_DELAY;
    check_eq("pready", 32'(pready), 32'h1);  // no wait states, two-cycle transfers.
    rdata = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t rdata;
    logic err;
    apb_transfer(1'b1, addr, data, rdata, err);
    check_eq("pslverr", 32'(err), 32'h0);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  // polls until done is set and nothing is in flight.
  task automatic wait_done();
    apb_data_t status;
    logic err;
    int polls;
    polls = 0;
    status = '0;
    while (status[1:0] != 2'b01) begin
      if (polls == POLL_LIMIT) begin
        stop_on_error("done was not set within 50 status polls");
      end
      apb_read(ADDR_STATUS, status, err);
      polls++;
    end
  endtask

  task automatic run_op(input op_e op, input posit_t p1, input posit_t p2,
                        output apb_data_t data);
    logic err;
    apb_write(ADDR_OPERANDS, {16'b0, p2, p1});
    apb_write(ADDR_CTRL, {30'b0, op});
    wait_done();
    apb_read(ADDR_RESULT, data, err);
    check_eq("pslverr", 32'(err), 32'h0);
  endtask

  task automatic check_op(input op_e op, input posit_t p1, input posit_t p2,
                          input posit_t exp_result, input logic exp_inexact);
    apb_data_t data;
    run_op(op, p1, p2, data);
    check_eq($sformatf("result %s 0x%0h 0x%0h", op.name(), p1, p2),
             32'(data[7:0]), 32'(exp_result));
    check_eq($sformatf("inexact %s 0x%0h 0x%0h", op.name(), p1, p2),
             32'(data[8]), 32'(exp_inexact));
  endtask

  // posit for +-2^k; regime of k+1 ones or -k zeros, clamped to maxpos and minpos.
  function automatic posit_t pow2_posit(input int k, input logic neg);
    logic [6:0] mag;
    posit_t word;
    if (k > MAX_K) begin
      mag = 7'h7F;
    end else if (k < -MAX_K) begin
      mag = 7'h01;
    end else if (k >= 0) begin
      mag = 7'h7F ^ (7'h7F >> (k + 1));
    end else begin
      mag = 7'h40 >> (-k);
    end
    word = {1'b0, mag};
    if (neg) begin
      word = -word;  // two's complement.
    end
    return word;
  endfunction

  task automatic test_reset_state();
    apb_data_t data;
    logic err;
    apb_read(ADDR_STATUS, data, err);
    check_eq("status", data, 32'h0);
    check_eq("pslverr", 32'(err), 32'h0);
    apb_read(ADDR_RESULT, data, err);
    check_eq("result", data, 32'h0);
    apb_read(apb_addr_t'('h10), data, err);
    check_eq("pslverr unmapped", 32'(err), 32'h1);
    check_eq("prdata unmapped", data, 32'h0);
  endtask

  task automatic test_exact();
    check_op(ADD, 8'h40, 8'h40, 8'h60, 1'b0);
    check_op(SUB, 8'h40, 8'h50, 8'hE0, 1'b0);
    check_op(MUL, 8'h50, 8'h60, 8'h68, 1'b0);
    check_op(DIV, 8'h40, 8'h60, 8'h20, 1'b0);
  endtask

  task automatic test_rounding();
    check_op(DIV, 8'h40, 8'h68, 8'h15, 1'b1);  // 1/3 is 2^-2 * 1.0101..
    check_op(MUL, 8'h7F, 8'h7F, 8'h7F, 1'b1);
    check_op(MUL, 8'h01, 8'h01, 8'h01, 1'b1);
  endtask

  task automatic test_specials();
    check_op(DIV, 8'h40, 8'h00, 8'h80, 1'b0);
    check_op(ADD, 8'h80, 8'h40, 8'h80, 1'b0);
    check_op(MUL, 8'h00, 8'h50, 8'h00, 1'b0);
    check_op(SUB, 8'h50, 8'h50, 8'h00, 1'b0);
  endtask

  task automatic test_random_mul();
    int ka, kb;
    logic sa, sb;
    integer r;
    for (int i = 0; i < 20; i++) begin
      r = $random(seed);
      ka = (r & 32'h7FFF_FFFF) % 7 - 3;
      r = $random(seed);
      kb = (r & 32'h7FFF_FFFF) % 7 - 3;
      r = $random(seed);
      sa = r[0];
      sb = r[1];
      check_op(MUL, pow2_posit(ka, sa), pow2_posit(kb, sb), pow2_posit(ka + kb, sa ^ sb),
               (ka + kb > MAX_K) || (ka + kb < -MAX_K));
    end
  endtask

  task automatic test_back_to_back();
    apb_data_t data;
    logic err;
    apb_write(ADDR_OPERANDS, {16'b0, 8'h60, 8'h50});
    apb_write(ADDR_CTRL, {30'b0, ADD});  // 1.5 + 2.
    apb_write(ADDR_CTRL, {30'b0, MUL});  // 1.5 * 2 lands last.
    wait_done();
    apb_read(ADDR_RESULT, data, err);
    check_eq("result back to back", data, 32'h68);
    apb_read(ADDR_STATUS, data, err);
    check_eq("status done", 32'(data[0]), 32'h0);
  endtask

  initial begin
    seed = 13902;
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_exact();
    test_rounding();
    test_specials();
    test_random_mul();
    test_back_to_back();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rtl/ppu_pkg.sv
rtl/posit_decode.sv
rtl/core_add_sub.sv
rtl/core_mul.sv
rtl/core_div.sv
rtl/core_op.sv
rtl/posit_encode.sv
rtl/ppu_apb_regs.sv
rtl/ppu_top.sv
testbench/tb_clock_gen.sv
testbench/ppu_assertions.sv
testbench/ppu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the PPU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module ppu_tb -f filelist.f -o Vppu_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vppu_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
else
  exit 1
fi
